//--- flist.f
logic/buffer_pkg.sv
logic/csr_pkg.sv
logic/tag_ram.sv
logic/write_data_buffer.sv
logic/buffer_csr.sv
logic/write_buffer_top.sv
test/write_buffer_assert.sv
test/write_buffer_tb.sv

//--- logic/buffer_csr.sv
// buffer register block
// AXI4-Lite slave with control bits, a sticky error flag and
// a saturating error counter fed by the buffer's error pulse

`timescale 1ns/1ps

module buffer_csr (
  input  logic               clock,
  input  logic               rstn,
  input  csr_pkg::axil_req_t axil_req,
  input  logic               data_write_error,
  output csr_pkg::axil_rsp_t axil_rsp,
  output logic               enable,
  output logic               err_enable
);

  typedef enum logic {WR_IDLE, WR_RESP} wr_state_t;
  typedef enum logic {RD_IDLE, RD_RESP} rd_state_t;

  wr_state_t wr_state;
  rd_state_t rd_state;

  logic wr_fire;
  logic rd_fire;
  logic status_clear;

  csr_pkg::axi_resp_t wr_resp;
  csr_pkg::axi_resp_t rd_resp;
  csr_pkg::axi_resp_t bresp_q;
  csr_pkg::axi_resp_t rresp_q;
  csr_pkg::csr_data_t rd_data;
  csr_pkg::csr_data_t rdata_q;

  logic                ctrl_enable_q;
  logic                ctrl_err_enable_q;
  logic                err_flag_q;
  csr_pkg::err_count_t err_count_q;

  // address and data taken together, one transaction at a time
  assign wr_fire = (wr_state == WR_IDLE) && axil_req.awvalid && axil_req.wvalid;
  assign rd_fire = (rd_state == RD_IDLE) && axil_req.arvalid;

  assign status_clear = wr_fire && (axil_req.awaddr == csr_pkg::STATUS_OFFSET) &&
                        axil_req.wdata[csr_pkg::STATUS_ERR_BIT];

  ////////////////////
  // write channel
  ////////////////////

  always_comb begin
    case (axil_req.awaddr)
      csr_pkg::CTRL_OFFSET,
      csr_pkg::STATUS_OFFSET,
      csr_pkg::ERR_COUNT_OFFSET: wr_resp = csr_pkg::OKAY;
      default:                   wr_resp = csr_pkg::SLVERR;
    endcase
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      wr_state <= WR_IDLE;
      bresp_q  <= csr_pkg::OKAY;
    end else begin
      case (wr_state)
        WR_IDLE: if (wr_fire) begin
          bresp_q  <= wr_resp;
          wr_state <= WR_RESP;
        end
        // hold the response until taken
        WR_RESP: if (axil_req.bready) begin
          wr_state <= WR_IDLE;
        end
        default: wr_state <= WR_IDLE;
      endcase
    end
  end

  ////////////////////
  // registers
  ////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      ctrl_enable_q     <= 1'b0;
      ctrl_err_enable_q <= 1'b0;
    end else if (wr_fire && (axil_req.awaddr == csr_pkg::CTRL_OFFSET)) begin
      ctrl_enable_q     <= axil_req.wdata[csr_pkg::CTRL_ENABLE_BIT];
      ctrl_err_enable_q <= axil_req.wdata[csr_pkg::CTRL_ERR_ENABLE_BIT];
    end
  end

  // set beats a clear in the same cycle
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      err_flag_q  <= 1'b0;
      err_count_q <= '0;
    end else begin
      if (data_write_error) begin
        err_flag_q <= 1'b1;
      end else if (status_clear) begin
        err_flag_q <= 1'b0;
      end
      // saturating count
      if (data_write_error && (err_count_q != csr_pkg::ERR_COUNT_MAX)) begin
        err_count_q <= err_count_q + 1'b1;
      end
    end
  end

  assign enable     = ctrl_enable_q;
  assign err_enable = ctrl_err_enable_q;

  ////////////////////
  // read channel
  ////////////////////

  always_comb begin
    rd_data = '0;
    rd_resp = csr_pkg::OKAY;
    case (axil_req.araddr)
      csr_pkg::CTRL_OFFSET: begin
        rd_data[csr_pkg::CTRL_ENABLE_BIT]     = ctrl_enable_q;
        rd_data[csr_pkg::CTRL_ERR_ENABLE_BIT] = ctrl_err_enable_q;
      end
      csr_pkg::STATUS_OFFSET:    rd_data[csr_pkg::STATUS_ERR_BIT] = err_flag_q;
      csr_pkg::ERR_COUNT_OFFSET: rd_data[csr_pkg::ERR_COUNT_W-1:0] = err_count_q;
      default:                   rd_resp = csr_pkg::SLVERR;
    endcase
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      rd_state <= RD_IDLE;
      rdata_q  <= '0;
      rresp_q  <= csr_pkg::OKAY;
    end else begin
      case (rd_state)
        RD_IDLE: if (rd_fire) begin
          rdata_q  <= rd_data;
          rresp_q  <= rd_resp;
          rd_state <= RD_RESP;
        end
        RD_RESP: if (axil_req.rready) begin
          rd_state <= RD_IDLE;
        end
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  always_comb begin
    axil_rsp.awready = wr_fire;
    axil_rsp.wready  = wr_fire;
    axil_rsp.bvalid  = (wr_state == WR_RESP);
    axil_rsp.bresp   = bresp_q;
    axil_rsp.arready = rd_fire;
    axil_rsp.rvalid  = (rd_state == RD_RESP);
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rresp   = rresp_q;
  end

endmodule

//--- logic/buffer_pkg.sv
// buffer data path definitions
// widths, vector types, buffer port structs and the parity helpers

package buffer_pkg;

  // tag and storage geometry
  localparam int TAG_W       = 8;
  localparam int RAM_DEPTH   = 1 << TAG_W;
  localparam int HALF_W      = 128;
  localparam int DW_PER_HALF = 2;
  localparam int DW_W        = HALF_W / DW_PER_HALF;
  localparam int LINE_ADDR_W = 6;
  localparam int LAT_W       = 4;

  // fixed read latency reported to the host
  localparam int READ_LATENCY = 3;

  typedef logic [TAG_W-1:0]       tag_t;
  typedef logic [HALF_W-1:0]      half_line_t;
  typedef logic [DW_PER_HALF-1:0] dw_parity_t;
  typedef logic [LINE_ADDR_W-1:0] line_addr_t;
  typedef logic [LAT_W-1:0]       latency_t;

  // one full line from the command side
  typedef struct packed {
    logic       valid;
    tag_t       tag;
    half_line_t half_0;
    half_line_t half_1;
  } write_cmd_t;

  // host read request, address zero picks half 0
  typedef struct packed {
    logic       read_valid;
    tag_t       read_tag;
    logic       read_tag_parity;
    line_addr_t read_address;
  } buffer_read_req_t;

  typedef struct packed {
    half_line_t read_data;
    dw_parity_t read_parity;
    latency_t   read_latency;
  } buffer_read_rsp_t;

  // odd parity, bit set when the tag has an even number of ones
  function automatic logic odd_parity_bit(input tag_t value);
    return ~^value;
  endfunction

  // one odd parity bit per 64-bit double word
  function automatic dw_parity_t dw_parity(input half_line_t data);
    dw_parity_t par;
    for (int i = 0; i < DW_PER_HALF; i++) begin
      par[i] = ~^data[i*DW_W +: DW_W];
    end
    return par;
  endfunction

endpackage

//--- logic/csr_pkg.sv
// register block definitions
// offsets, field positions and the AXI4-Lite channel structs

package csr_pkg;

  localparam int CSR_ADDR_W = 4;
  localparam int CSR_DATA_W = 32;

  typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
  typedef logic [CSR_DATA_W-1:0] csr_data_t;
  typedef logic [1:0]            axi_resp_t;

  // register map
  localparam csr_addr_t CTRL_OFFSET      = 4'h0;
  localparam csr_addr_t STATUS_OFFSET    = 4'h4;
  localparam csr_addr_t ERR_COUNT_OFFSET = 4'h8;

  // control and status fields
  localparam int CTRL_ENABLE_BIT     = 0;
  localparam int CTRL_ERR_ENABLE_BIT = 1;
  localparam int STATUS_ERR_BIT      = 0;

  // error counter, low half of its register
  localparam int ERR_COUNT_W = 16;
  typedef logic [ERR_COUNT_W-1:0] err_count_t;
  localparam err_count_t ERR_COUNT_MAX = 16'hFFFF;

  localparam axi_resp_t OKAY   = 2'b00;
  localparam axi_resp_t SLVERR = 2'b10;

  // master side of the bus
  typedef struct packed {
    logic      awvalid;
    csr_addr_t awaddr;
    logic      wvalid;
    csr_data_t wdata;
    logic      bready;
    logic      arvalid;
    csr_addr_t araddr;
    logic      rready;
  } axil_req_t;

  // slave side of the bus
  typedef struct packed {
    logic      awready;
    logic      wready;
    logic      bvalid;
    axi_resp_t bresp;
    logic      arready;
    logic      rvalid;
    csr_data_t rdata;
    axi_resp_t rresp;
  } axil_rsp_t;

endpackage

//--- logic/tag_ram.sv
// tag indexed half-line storage
// synchronous write, asynchronous read, one entry per tag

`timescale 1ns/1ps

module tag_ram (
  input  logic                   clock,
  input  logic                   we,
  input  buffer_pkg::tag_t       wr_addr,
  input  buffer_pkg::half_line_t data_in,
  input  buffer_pkg::tag_t       rd_addr,
  output buffer_pkg::half_line_t data_out
);

  // one half-line per tag
  buffer_pkg::half_line_t mem [buffer_pkg::RAM_DEPTH];

  always_ff @(posedge clock) begin
    if (we) begin
      mem[wr_addr] <= data_in;
    end
  end

  // read port sees the previous edge's write
  assign data_out = mem[rd_addr];

endmodule

//--- logic/write_buffer_top.sv
// write buffer top level
// register block steering the tag indexed write data buffer

`timescale 1ns/1ps

module write_buffer_top (
  input  logic                         clock,
  input  logic                         rstn,
  input  csr_pkg::axil_req_t           axil_req,
  input  buffer_pkg::write_cmd_t       write_cmd,
  input  buffer_pkg::buffer_read_req_t read_req,
  output csr_pkg::axil_rsp_t           axil_rsp,
  output buffer_pkg::buffer_read_rsp_t read_rsp,
  output logic                         data_write_error
);

  // control from the register block
  logic enable;
  logic err_enable;

  buffer_csr csr_i (
    .clock            (clock),
    .rstn             (rstn),
    .axil_req         (axil_req),
    .data_write_error (data_write_error),
    .axil_rsp         (axil_rsp),
    .enable           (enable),
    .err_enable       (err_enable)
  );

  // error pulse goes both out and back to the counter
  write_data_buffer buffer_i (
    .clock            (clock),
    .rstn             (rstn),
    .enable_in        (enable),
    .err_enable       (err_enable),
    .write_cmd        (write_cmd),
    .read_req         (read_req),
    .read_rsp         (read_rsp),
    .data_write_error (data_write_error)
  );

endmodule

//--- logic/write_data_buffer.sv
// write data buffer
// stores command lines by tag in two half-line RAMs and serves
// tagged half-line reads with fixed latency, data parity and a tag parity check

`timescale 1ns/1ps

module write_data_buffer (
  input  logic                         clock,
  input  logic                         rstn,
  input  logic                         enable_in,
  input  logic                         err_enable,
  input  buffer_pkg::write_cmd_t       write_cmd,
  input  buffer_pkg::buffer_read_req_t read_req,
  output buffer_pkg::buffer_read_rsp_t read_rsp,
  output logic                         data_write_error
);

  logic enabled;

  // latched write command
  logic                   wr_valid_q;
  buffer_pkg::tag_t       wr_tag_q;
  buffer_pkg::half_line_t wr_half_0_q;
  buffer_pkg::half_line_t wr_half_1_q;

  // registered read request
  logic                   rd_valid_q;
  buffer_pkg::tag_t       rd_tag_q;
  buffer_pkg::line_addr_t rd_addr_q;
  logic                   rd_par_q;

  buffer_pkg::half_line_t ram_0_out;
  buffer_pkg::half_line_t ram_1_out;

  // read data pipeline
  buffer_pkg::half_line_t sel_data_q;
  buffer_pkg::half_line_t pipe_data_q;
  buffer_pkg::half_line_t out_data_q;

  // tag parity error pipeline
  logic tag_err_q;
  logic err_d1_q;
  logic err_d2_q;

  ////////////////////
  // enable
  ////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      enabled <= 1'b0;
    end else begin
      enabled <= enable_in;
    end
  end

  ////////////////////
  // write side
  ////////////////////

  // valid drops while disabled so nothing is written twice
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      wr_valid_q <= 1'b0;
    end else begin
      wr_valid_q <= enabled && write_cmd.valid;
    end
  end

  always_ff @(posedge clock) begin
    if (enabled && write_cmd.valid) begin
      wr_tag_q    <= write_cmd.tag;
      wr_half_0_q <= write_cmd.half_0;
      wr_half_1_q <= write_cmd.half_1;
    end
  end

  tag_ram half_0_ram_i (
    .clock    (clock),
    .we       (wr_valid_q),
    .wr_addr  (wr_tag_q),
    .data_in  (wr_half_0_q),
    .rd_addr  (rd_tag_q),
    .data_out (ram_0_out)
  );

  tag_ram half_1_ram_i (
    .clock    (clock),
    .we       (wr_valid_q),
    .wr_addr  (wr_tag_q),
    .data_in  (wr_half_1_q),
    .rd_addr  (rd_tag_q),
    .data_out (ram_1_out)
  );

  ////////////////////
  // read side
  ////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= enabled && read_req.read_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (enabled && read_req.read_valid) begin
      rd_tag_q  <= read_req.read_tag;
      rd_addr_q <= read_req.read_address;
      rd_par_q  <= read_req.read_tag_parity;
    end
  end

  // half select, then two stages to the port
  // idle slots carry all ones
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      sel_data_q  <= '1;
      pipe_data_q <= '1;
      out_data_q  <= '1;
    end else begin
      if (!rd_valid_q) begin
        sel_data_q <= '1;
      end else if (rd_addr_q == '0) begin
        sel_data_q <= ram_0_out;
      end else begin
        sel_data_q <= ram_1_out;
      end
      pipe_data_q <= sel_data_q;
      out_data_q  <= pipe_data_q;
    end
  end

  always_comb begin
    read_rsp.read_data    = out_data_q;
    read_rsp.read_parity  = buffer_pkg::dw_parity(out_data_q);
    read_rsp.read_latency = buffer_pkg::LAT_W'(buffer_pkg::READ_LATENCY);
  end

  ////////////////////
  // tag parity check
  ////////////////////

  // mismatch of recomputed and sent parity, one cycle behind the data
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      tag_err_q        <= 1'b0;
      err_d1_q         <= 1'b0;
      err_d2_q         <= 1'b0;
      data_write_error <= 1'b0;
    end else begin
      tag_err_q        <= rd_valid_q && (buffer_pkg::odd_parity_bit(rd_tag_q) != rd_par_q);
      err_d1_q         <= tag_err_q;
      err_d2_q         <= err_d1_q;
      // masked when reporting is off
      data_write_error <= err_d2_q && err_enable;
    end
  end

endmodule

//--- test/write_buffer_assert.sv
// buffer timing assertions
// idle read slots and error pulse width

`timescale 1ns/1ps

module write_buffer_assert (
  input logic                         clock,
  input logic                         rstn,
  input logic                         enabled,
  input buffer_pkg::buffer_read_req_t read_req,
  input buffer_pkg::half_line_t       read_data,
  input logic                         data_write_error
);

  // count of failed assertions
  int fail_count = 0;

  // enabled request whose tag and parity bit hold an even count of ones
  logic bad_req;

  assign bad_req = enabled && read_req.read_valid &&
                   !(^{read_req.read_tag, read_req.read_tag_parity});

  // slot without an enabled read reaches the port as all ones
  idle_slot_a: assert property (@(posedge clock) disable iff (!rstn)
    !(enabled && read_req.read_valid) |-> ##4 (read_data == '1))
    else begin
      fail_count = fail_count + 1;
      $error("read data not all ones after an idle read slot");
    end

  // no second pulse without a bad request behind it
  pulse_width_a: assert property (@(posedge clock) disable iff (!rstn)
    (data_write_error && !$past(bad_req, 4)) |=> !data_write_error)
    else begin
      fail_count = fail_count + 1;
      $error("error pulse longer than one cycle");
    end

endmodule

bind write_data_buffer write_buffer_assert buffer_assert_i (
  .clock            (clock),
  .rstn             (rstn),
  .enabled          (enabled),
  .read_req         (read_req),
  .read_data        (read_rsp.read_data),
  .data_write_error (data_write_error)
);

//--- test/write_buffer_tb.sv
// write buffer testbench
// drives the register bus and the buffer ports and checks every cycle
// against a reference model of the line store

`timescale 1ns/1ps

module write_buffer_tb;

  localparam int TIMEOUT_CYCLES = 2000;

  // expected outcome of one read request
  typedef struct packed {
    buffer_pkg::half_line_t data;
    buffer_pkg::dw_parity_t par;
    logic                   err;
  } ref_result_t;

  typedef struct {
    int                     due;
    buffer_pkg::half_line_t data;
    buffer_pkg::dw_parity_t par;
  } read_exp_t;

  logic                         clock;
  logic                         rstn;
  csr_pkg::axil_req_t           axil_req;
  csr_pkg::axil_rsp_t           axil_rsp;
  buffer_pkg::write_cmd_t       write_cmd;
  buffer_pkg::buffer_read_req_t read_req;
  buffer_pkg::buffer_read_rsp_t read_rsp;
  logic                         data_write_error;

  // model of both RAMs
  buffer_pkg::half_line_t model_h0 [buffer_pkg::RAM_DEPTH];
  buffer_pkg::half_line_t model_h1 [buffer_pkg::RAM_DEPTH];
  // model enable lags the control write
  logic en_prev;
  logic en_now;
  logic err_en_model;
  int   en_edge;

  read_exp_t              data_q [$];
  int                     err_q [$];
  int                     cycle;
  int                     errors;
  logic [31:0]            lfsr_state;
  buffer_pkg::half_line_t exp_data;
  buffer_pkg::dw_parity_t exp_par;
  logic                   exp_err;
  buffer_pkg::tag_t       tags [8];

  write_buffer_top write_buffer_top_i (
    .clock            (clock),
    .rstn             (rstn),
    .axil_req         (axil_req),
    .write_cmd        (write_cmd),
    .read_req         (read_req),
    .axil_rsp         (axil_rsp),
    .read_rsp         (read_rsp),
    .data_write_error (data_write_error)
  );

  always #10 clock = ~clock;

  ////////////////////
  // helpers
  ////////////////////

  // galois form with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // one lfsr step per bit taken
  function automatic logic [127:0] rand_bits(input int nbits);
    logic [127:0] v;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v[i] = lfsr_state[0];
    end
    return v;
  endfunction

  // bit set when the word holds an even count of ones
  function automatic buffer_pkg::dw_parity_t dw_odd_parity(input buffer_pkg::half_line_t d);
    buffer_pkg::dw_parity_t p;
    for (int i = 0; i < 2; i++) begin
      p[i] = ($countones(d[i*64 +: 64]) % 2) == 0;
    end
    return p;
  endfunction

  function automatic logic enabled_at(input int edge_idx);
    return (edge_idx >= en_edge) ? en_now : en_prev;
  endfunction

  // reference for one read gives stored half, its parity and tag parity error
  function automatic ref_result_t expect_read(input buffer_pkg::tag_t tag,
      input buffer_pkg::line_addr_t addr, input logic par_bit);
    ref_result_t r;
    r.data = (addr == '0) ? model_h0[tag] : model_h1[tag];
    r.par  = dw_odd_parity(r.data);
    r.err  = err_en_model && (par_bit != (($countones(tag) % 2) == 0));
    return r;
  endfunction

  task automatic fail_stop();
    $display("tests failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH time %0t %s got %h expected %h", $time, name, got, exp);
      fail_stop();
    end
  endtask

  ////////////////////
  // bus tasks
  ////////////////////

  task automatic axil_write(input csr_pkg::csr_addr_t addr, input csr_pkg::csr_data_t data,
      input csr_pkg::axi_resp_t exp_resp);
    @(negedge clock);
    axil_req.awvalid = 1'b1;
    axil_req.awaddr  = addr;
    axil_req.wvalid  = 1'b1;
    axil_req.wdata   = data;
    axil_req.bready  = 1'b1;
    @(posedge clock);
    while (!axil_rsp.awready) begin
      @(posedge clock);
    end
    check("wready", axil_rsp.wready, 1'b1);
    @(negedge clock);
    // buffer sees new control two edges after the handshake
    if (addr == csr_pkg::CTRL_OFFSET) begin
      en_prev      = en_now;
      en_now       = data[0];
      en_edge      = cycle + 2;
      err_en_model = data[1];
    end
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    while (!axil_rsp.bvalid) begin
      @(negedge clock);
    end
    check("bresp", axil_rsp.bresp, exp_resp);
    @(posedge clock);
    @(negedge clock);
    axil_req.bready = 1'b0;
  endtask

  task automatic axil_read(input csr_pkg::csr_addr_t addr, input csr_pkg::csr_data_t exp_data,
      input csr_pkg::axi_resp_t exp_resp);
    @(negedge clock);
    axil_req.arvalid = 1'b1;
    axil_req.araddr  = addr;
    axil_req.rready  = 1'b1;
    @(posedge clock);
    while (!axil_rsp.arready) begin
      @(posedge clock);
    end
    @(negedge clock);
    axil_req.arvalid = 1'b0;
    while (!axil_rsp.rvalid) begin
      @(negedge clock);
    end
    check("rresp", axil_rsp.rresp, exp_resp);
    if (exp_resp == csr_pkg::OKAY) begin
      check("rdata", axil_rsp.rdata, exp_data);
    end
    @(posedge clock);
    @(negedge clock);
    axil_req.rready = 1'b0;
  endtask

  ////////////////////
  // buffer tasks
  ////////////////////

  task automatic send_write(input buffer_pkg::tag_t tag, input buffer_pkg::half_line_t h0,
      input buffer_pkg::half_line_t h1);
    @(negedge clock);
    write_cmd.valid  = 1'b1;
    write_cmd.tag    = tag;
    write_cmd.half_0 = h0;
    write_cmd.half_1 = h1;
    // dropped while disabled
    if (enabled_at(cycle + 1)) begin
      model_h0[tag] = h0;
      model_h1[tag] = h1;
    end
  endtask

  // request sampled at edge cycle+1 gives data four compares later and the error one after
  task automatic issue_read(input buffer_pkg::tag_t tag, input buffer_pkg::line_addr_t addr,
      input logic flip);
    ref_result_t r;
    read_exp_t   e;
    @(negedge clock);
    read_req.read_valid      = 1'b1;
    read_req.read_tag        = tag;
    read_req.read_tag_parity = ((($countones(tag) % 2) == 0) ? 1'b1 : 1'b0) ^ flip;
    read_req.read_address    = addr;
    if (enabled_at(cycle + 1)) begin
      r      = expect_read(tag, addr, read_req.read_tag_parity);
      e.due  = cycle + 5;
      e.data = r.data;
      e.par  = r.par;
      data_q.push_back(e);
      if (r.err) begin
        err_q.push_back(cycle + 6);
      end
    end
  endtask

  task automatic idle_ports();
    @(negedge clock);
    write_cmd.valid     = 1'b0;
    read_req.read_valid = 1'b0;
  endtask

  task automatic drain();
    while (data_q.size() != 0 || err_q.size() != 0) begin
      @(negedge clock);
    end
  endtask

  ////////////////////
  // compare
  ////////////////////

  // idle slots expect all ones and no error
  always @(posedge clock) begin
    cycle = cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      fail_stop();
    end else if (rstn) begin
      exp_data = '1;
      exp_par  = dw_odd_parity('1);
      if (data_q.size() != 0 && data_q[0].due == cycle) begin
        exp_data = data_q[0].data;
        exp_par  = data_q[0].par;
        void'(data_q.pop_front());
      end
      exp_err = 1'b0;
      if (err_q.size() != 0 && err_q[0] == cycle) begin
        exp_err = 1'b1;
        void'(err_q.pop_front());
      end
      check("read_data", read_rsp.read_data, exp_data);
      check("read_parity", read_rsp.read_parity, exp_par);
      check("read_latency", read_rsp.read_latency, 4'd3);
      check("data_write_error", data_write_error, exp_err);
      if (write_buffer_top_i.buffer_i.buffer_assert_i.fail_count != 0) begin
        $display("a buffer timing assertion failed");
        fail_stop();
      end
    end
  end

  ////////////////////
  // stimulus
  ////////////////////

  initial begin
    buffer_pkg::line_addr_t addr;
    clock        = 1'b0;
    rstn         = 1'b0;
    axil_req     = '0;
    write_cmd    = '0;
    read_req     = '0;
    lfsr_state   = 32'h7bcf_5425;
    cycle        = 0;
    errors       = 0;
    en_prev      = 1'b0;
    en_now       = 1'b0;
    en_edge      = 0;
    err_en_model = 1'b0;
    repeat (3) @(negedge clock);
    rstn = 1'b1;

    // reset values and a disabled buffer ignoring traffic
    axil_read(csr_pkg::CTRL_OFFSET, 32'h0, csr_pkg::OKAY);
    axil_read(csr_pkg::ERR_COUNT_OFFSET, 32'h0, csr_pkg::OKAY);
    send_write(8'h5a, rand_bits(128), rand_bits(128));
    issue_read(8'h5a, 6'h00, 1'b0);
    issue_read(8'h5a, 6'h01, 1'b1);
    idle_ports();
    repeat (5) @(negedge clock);

    // random lines with both halves read back to back
    axil_write(csr_pkg::CTRL_OFFSET, 32'h1, csr_pkg::OKAY);
    for (int i = 0; i < 8; i++) begin
      tags[i] = buffer_pkg::tag_t'(rand_bits(8));
      send_write(tags[i], rand_bits(128), rand_bits(128));
    end
    idle_ports();
    for (int i = 0; i < 8; i++) begin
      addr = buffer_pkg::line_addr_t'(rand_bits(6));
      issue_read(tags[i], 6'h00, 1'b0);
      issue_read(tags[i], (addr == '0) ? 6'h01 : addr, 1'b0);
    end
    idle_ports();
    drain();

    // later write to the same tag wins
    send_write(8'hc3, rand_bits(128), rand_bits(128));
    send_write(8'hc3, rand_bits(128), rand_bits(128));
    idle_ports();
    issue_read(8'hc3, 6'h00, 1'b0);
    issue_read(8'hc3, 6'h3f, 1'b0);
    idle_ports();
    drain();

    // error reporting on with a bad tag parity on every odd request
    axil_write(csr_pkg::CTRL_OFFSET, 32'h3, csr_pkg::OKAY);
    for (int i = 0; i < 6; i++) begin
      issue_read(tags[i], buffer_pkg::line_addr_t'(rand_bits(6)), i[0]);
    end
    idle_ports();
    drain();
    axil_read(csr_pkg::ERR_COUNT_OFFSET, 32'd3, csr_pkg::OKAY);
    axil_read(csr_pkg::STATUS_OFFSET, 32'h1, csr_pkg::OKAY);
    axil_write(csr_pkg::STATUS_OFFSET, 32'h1, csr_pkg::OKAY);
    axil_read(csr_pkg::STATUS_OFFSET, 32'h0, csr_pkg::OKAY);

    // reporting off while data is still returned
    axil_write(csr_pkg::CTRL_OFFSET, 32'h1, csr_pkg::OKAY);
    for (int i = 0; i < 4; i++) begin
      issue_read(tags[i], buffer_pkg::line_addr_t'(rand_bits(6)), 1'b1);
    end
    idle_ports();
    drain();
    axil_read(csr_pkg::ERR_COUNT_OFFSET, 32'd3, csr_pkg::OKAY);

    // disabled buffer keeps the stored line of a tag
    axil_write(csr_pkg::CTRL_OFFSET, 32'h0, csr_pkg::OKAY);
    send_write(tags[0], rand_bits(128), rand_bits(128));
    idle_ports();
    axil_write(csr_pkg::CTRL_OFFSET, 32'h1, csr_pkg::OKAY);
    issue_read(tags[0], 6'h00, 1'b0);
    issue_read(tags[0], 6'h01, 1'b0);
    idle_ports();
    drain();

    // unmapped offset and control readback
    axil_read(4'hc, 32'h0, csr_pkg::SLVERR);
    axil_write(4'hc, 32'hffff_ffff, csr_pkg::SLVERR);
    axil_write(csr_pkg::CTRL_OFFSET, 32'h3, csr_pkg::OKAY);
    axil_read(csr_pkg::CTRL_OFFSET, 32'h3, csr_pkg::OKAY);
    repeat (5) @(negedge clock);

    if (errors == 0 && write_buffer_top_i.buffer_i.buffer_assert_i.fail_count == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      fail_stop();
    end
  end

endmodule
